// ==== hdl/pixel_scanner.sv ====
`timescale 1ns/1ps

module pixel_scanner (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  logic                ray_pop,
	output logic                issue_valid,
	output prg_pkg::col_t       issue_col,
	output prg_pkg::row_t       issue_row,
	output prg_pkg::pixel_id_t  issue_pixel_id,
	output logic                busy
);
	import prg_pkg::*;

	scan_state_t state;
	scan_state_t next_state;
	credit_t     credit;
	logic        last_pixel;
	logic        end_of_line;

	// Issue only while the FIFO is guaranteed a free slot for the ray
	assign issue_valid = (state == ACTIVE) && (credit < credit_t'(FIFO_DEPTH));

	assign last_pixel  = (issue_pixel_id == pixel_id_t'(NUM_RAYS - 1));
	assign end_of_line = (issue_col == col_t'(NUM_COLS - 1));

	assign busy = (state == ACTIVE) || (credit != '0);

	// ########################################################################
	// Frame FSM
	// ########################################################################

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (start && !busy)
					next_state = ACTIVE;
			end
			ACTIVE: begin
				if (issue_valid && last_pixel)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Rows are scanned from the top of the image down to row zero
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			issue_col      <= '0;
			issue_row      <= row_t'(NUM_ROWS - 1);
			issue_pixel_id <= '0;
		end else if (issue_valid) begin
			if (last_pixel) begin
				issue_col      <= '0;
				issue_row      <= row_t'(NUM_ROWS - 1);
				issue_pixel_id <= '0;
			end else begin
				issue_pixel_id <= issue_pixel_id + 1'b1;
				if (end_of_line) begin
					issue_col <= '0;
					issue_row <= issue_row - 1'b1;
				end else begin
					issue_col <= issue_col + 1'b1;
				end
			end
		end
	end

	// ########################################################################
	// Credits for rays issued but not yet taken by the shader
	// ########################################################################

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			credit <= '0;
		else begin
			case ({issue_valid, ray_pop})
				2'b10:   credit <= credit + 1'b1;
				2'b01:   credit <= credit - 1'b1;
				default: credit <= credit;
			endcase
		end
	end

	credit_bound: assert property (@(posedge clk) disable iff (rst)
		credit <= credit_t'(FIFO_DEPTH))
		else $error("credit count above FIFO depth");

	pop_has_credit: assert property (@(posedge clk) disable iff (rst)
		ray_pop |-> credit != '0)
		else $error("ray taken with no ray outstanding");

endmodule : pixel_scanner

// ==== hdl/prg.sv ====
`timescale 1ns/1ps

module prg (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  prg_pkg::coord_t     eye_x,
	input  prg_pkg::coord_t     eye_y,
	input  prg_pkg::coord_t     eye_z,
	input  prg_pkg::coord_t     u_x,
	input  prg_pkg::coord_t     u_y,
	input  prg_pkg::coord_t     u_z,
	input  prg_pkg::coord_t     v_x,
	input  prg_pkg::coord_t     v_y,
	input  prg_pkg::coord_t     v_z,
	input  prg_pkg::coord_t     w_x,
	input  prg_pkg::coord_t     w_y,
	input  prg_pkg::coord_t     w_z,
	input  prg_pkg::coord_t     pw,
	input  logic                ray_ready,
	output logic                ray_valid,
	output prg_pkg::coord_t     ray_origin_x,
	output prg_pkg::coord_t     ray_origin_y,
	output prg_pkg::coord_t     ray_origin_z,
	output prg_pkg::coord_t     ray_dir_x,
	output prg_pkg::coord_t     ray_dir_y,
	output prg_pkg::coord_t     ray_dir_z,
	output prg_pkg::pixel_id_t  ray_pixel_id,
	output logic                busy
);
	import prg_pkg::*;

	logic      issue_valid;
	col_t      issue_col;
	row_t      issue_row;
	pixel_id_t issue_pixel_id;
	logic      pipe_valid;
	pixel_id_t pipe_pixel_id;
	coord_t    pipe_origin_x, pipe_origin_y, pipe_origin_z;
	coord_t    pipe_dir_x, pipe_dir_y, pipe_dir_z;
	logic      ray_pop;

	// A transfer to the shader hands a credit back to the scanner
	assign ray_pop = ray_valid && ray_ready;

	pixel_scanner i_scanner (
		.clk, .rst, .start, .ray_pop,
		.issue_valid, .issue_col, .issue_row, .issue_pixel_id, .busy
	);

	ray_dir_pipe i_pipe (
		.clk, .rst, .issue_valid, .issue_col, .issue_row, .issue_pixel_id,
		.eye_x, .eye_y, .eye_z, .u_x, .u_y, .u_z,
		.v_x, .v_y, .v_z, .w_x, .w_y, .w_z, .pw,
		.pipe_valid, .pipe_pixel_id,
		.pipe_origin_x, .pipe_origin_y, .pipe_origin_z,
		.pipe_dir_x, .pipe_dir_y, .pipe_dir_z
	);

	ray_fifo i_fifo (
		.clk, .rst,
		.wr_valid(pipe_valid), .wr_pixel_id(pipe_pixel_id),
		.wr_origin_x(pipe_origin_x), .wr_origin_y(pipe_origin_y),
		.wr_origin_z(pipe_origin_z),
		.wr_dir_x(pipe_dir_x), .wr_dir_y(pipe_dir_y), .wr_dir_z(pipe_dir_z),
		.rd_ready(ray_ready), .rd_valid(ray_valid), .rd_pixel_id(ray_pixel_id),
		.rd_origin_x(ray_origin_x), .rd_origin_y(ray_origin_y),
		.rd_origin_z(ray_origin_z),
		.rd_dir_x(ray_dir_x), .rd_dir_y(ray_dir_y), .rd_dir_z(ray_dir_z)
	);

endmodule : prg

// ==== hdl/prg_pkg.sv ====
package prg_pkg;

	// ########################################################################
	// Frame geometry
	// ########################################################################

	localparam int NUM_COLS = 8;
	localparam int NUM_ROWS = 6;
	localparam int NUM_RAYS = NUM_COLS * NUM_ROWS;

	// ########################################################################
	// Number format and pipeline sizing
	// ########################################################################

	// Signed Q8.8, so one unit is 1 << FRAC_BITS
	localparam int FRAC_BITS = 8;

	localparam int PIPE_LATENCY = 3;

	// Also the limit on rays in flight between scanner and shader
	localparam int FIFO_DEPTH = 8;

	// ########################################################################
	// Types
	// ########################################################################

	typedef logic signed [15:0] coord_t;

	typedef logic [$clog2(NUM_COLS)-1:0] col_t;
	typedef logic [$clog2(NUM_ROWS)-1:0] row_t;
	typedef logic [$clog2(NUM_RAYS)-1:0] pixel_id_t;

	// One bit wider than a pointer so a full FIFO's worth of credits fits
	typedef logic [$clog2(FIFO_DEPTH):0] credit_t;

	typedef enum logic {
		IDLE,
		ACTIVE
	} scan_state_t;

endpackage : prg_pkg

// ==== hdl/ray_dir_pipe.sv ====
`timescale 1ns/1ps

module ray_dir_pipe (
	input  logic                clk,
	input  logic                rst,
	input  logic                issue_valid,
	input  prg_pkg::col_t       issue_col,
	input  prg_pkg::row_t       issue_row,
	input  prg_pkg::pixel_id_t  issue_pixel_id,
	input  prg_pkg::coord_t     eye_x,
	input  prg_pkg::coord_t     eye_y,
	input  prg_pkg::coord_t     eye_z,
	input  prg_pkg::coord_t     u_x,
	input  prg_pkg::coord_t     u_y,
	input  prg_pkg::coord_t     u_z,
	input  prg_pkg::coord_t     v_x,
	input  prg_pkg::coord_t     v_y,
	input  prg_pkg::coord_t     v_z,
	input  prg_pkg::coord_t     w_x,
	input  prg_pkg::coord_t     w_y,
	input  prg_pkg::coord_t     w_z,
	input  prg_pkg::coord_t     pw,
	output logic                pipe_valid,
	output prg_pkg::pixel_id_t  pipe_pixel_id,
	output prg_pkg::coord_t     pipe_origin_x,
	output prg_pkg::coord_t     pipe_origin_y,
	output prg_pkg::coord_t     pipe_origin_z,
	output prg_pkg::coord_t     pipe_dir_x,
	output prg_pkg::coord_t     pipe_dir_y,
	output prg_pkg::coord_t     pipe_dir_z
);
	import prg_pkg::*;

	logic [PIPE_LATENCY-1:0] valid_sr;
	pixel_id_t               pid_sr [PIPE_LATENCY];

	coord_t x_off;
	coord_t y_off;
	coord_t s1_su;
	coord_t s1_sv;
	coord_t s2_ux;
	coord_t s2_uy;
	coord_t s2_uz;
	coord_t s2_vx;
	coord_t s2_vy;
	coord_t s2_vz;

	// Full 32-bit product, then back to Q8.8
	function automatic coord_t scale(input coord_t a, input coord_t b);
		logic signed [31:0] prod;
		prod = a * b;
		return coord_t'(prod >>> FRAC_BITS);
	endfunction

	// ########################################################################
	// Valid and pixel number travel beside the data
	// ########################################################################

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			valid_sr <= '0;
		else
			valid_sr <= {valid_sr[PIPE_LATENCY-2:0], issue_valid};
	end

	always_ff @(posedge clk) begin
		pid_sr[0] <= issue_pixel_id;
		for (int i = 1; i < PIPE_LATENCY; i++)
			pid_sr[i] <= pid_sr[i-1];
	end

	assign pipe_valid    = valid_sr[PIPE_LATENCY-1];
	assign pipe_pixel_id = pid_sr[PIPE_LATENCY-1];

	// Offsets from the image centre, in whole pixels
	assign x_off = coord_t'(issue_col) - coord_t'(NUM_COLS / 2);
	assign y_off = coord_t'(issue_row) - coord_t'(NUM_ROWS / 2);

	// ########################################################################
	// Stage 1 to 3 datapath
	// ########################################################################

	always_ff @(posedge clk) begin
		// Integer offset times a Q8.8 width stays Q8.8, wrapped to 16 bits
		s1_su <= x_off * pw;
		s1_sv <= y_off * pw;

		s2_ux <= scale(s1_su, u_x);
		s2_uy <= scale(s1_su, u_y);
		s2_uz <= scale(s1_su, u_z);
		s2_vx <= scale(s1_sv, v_x);
		s2_vy <= scale(s1_sv, v_y);
		s2_vz <= scale(s1_sv, v_z);

		pipe_dir_x    <= w_x + s2_ux + s2_vx;
		pipe_dir_y    <= w_y + s2_uy + s2_vy;
		pipe_dir_z    <= w_z + s2_uz + s2_vz;
		pipe_origin_x <= eye_x;
		pipe_origin_y <= eye_y;
		pipe_origin_z <= eye_z;
	end

endmodule : ray_dir_pipe

// ==== hdl/ray_fifo.sv ====
`timescale 1ns/1ps

module ray_fifo (
	input  logic                clk,
	input  logic                rst,
	input  logic                wr_valid,
	input  prg_pkg::pixel_id_t  wr_pixel_id,
	input  prg_pkg::coord_t     wr_origin_x,
	input  prg_pkg::coord_t     wr_origin_y,
	input  prg_pkg::coord_t     wr_origin_z,
	input  prg_pkg::coord_t     wr_dir_x,
	input  prg_pkg::coord_t     wr_dir_y,
	input  prg_pkg::coord_t     wr_dir_z,
	input  logic                rd_ready,
	output logic                rd_valid,
	output prg_pkg::pixel_id_t  rd_pixel_id,
	output prg_pkg::coord_t     rd_origin_x,
	output prg_pkg::coord_t     rd_origin_y,
	output prg_pkg::coord_t     rd_origin_z,
	output prg_pkg::coord_t     rd_dir_x,
	output prg_pkg::coord_t     rd_dir_y,
	output prg_pkg::coord_t     rd_dir_z
);
	import prg_pkg::*;

	pixel_id_t mem_pid [FIFO_DEPTH];
	coord_t    mem_ox  [FIFO_DEPTH];
	coord_t    mem_oy  [FIFO_DEPTH];
	coord_t    mem_oz  [FIFO_DEPTH];
	coord_t    mem_dx  [FIFO_DEPTH];
	coord_t    mem_dy  [FIFO_DEPTH];
	coord_t    mem_dz  [FIFO_DEPTH];

	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(FIFO_DEPTH):0]   count;
	logic                          do_read;

	assign rd_valid = (count != '0);
	assign do_read  = rd_valid && rd_ready;

	always_ff @(posedge clk) begin
		if (wr_valid) begin
			mem_pid[wr_ptr] <= wr_pixel_id;
			mem_ox[wr_ptr]  <= wr_origin_x;
			mem_oy[wr_ptr]  <= wr_origin_y;
			mem_oz[wr_ptr]  <= wr_origin_z;
			mem_dx[wr_ptr]  <= wr_dir_x;
			mem_dy[wr_ptr]  <= wr_dir_y;
			mem_dz[wr_ptr]  <= wr_dir_z;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_valid)
				wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (wr_valid && !do_read)
				count <= count + 1'b1;
			else if (!wr_valid && do_read)
				count <= count - 1'b1;
		end
	end

	// Head entry is shown directly, so it holds while the shader stalls
	assign rd_pixel_id = mem_pid[rd_ptr];
	assign rd_origin_x = mem_ox[rd_ptr];
	assign rd_origin_y = mem_oy[rd_ptr];
	assign rd_origin_z = mem_oz[rd_ptr];
	assign rd_dir_x    = mem_dx[rd_ptr];
	assign rd_dir_y    = mem_dy[rd_ptr];
	assign rd_dir_z    = mem_dz[rd_ptr];

	no_overflow: assert property (@(posedge clk) disable iff (rst)
		wr_valid |-> count < FIFO_DEPTH)
		else $error("ray written into a full FIFO");

endmodule : ray_fifo

// ==== project.f ====
hdl/prg_pkg.sv
hdl/pixel_scanner.sv
hdl/ray_dir_pipe.sv
hdl/ray_fifo.sv
hdl/prg.sv
testbench/prg_checker.sv
testbench/prg_tb.sv

// ==== testbench/prg_checker.sv ====
`timescale 1ns/1ps

module prg_checker (
	input  logic                clk,
	input  logic                rst,
	input  prg_pkg::coord_t     eye_x,
	input  prg_pkg::coord_t     eye_y,
	input  prg_pkg::coord_t     eye_z,
	input  prg_pkg::coord_t     u_x,
	input  prg_pkg::coord_t     u_y,
	input  prg_pkg::coord_t     u_z,
	input  prg_pkg::coord_t     v_x,
	input  prg_pkg::coord_t     v_y,
	input  prg_pkg::coord_t     v_z,
	input  prg_pkg::coord_t     w_x,
	input  prg_pkg::coord_t     w_y,
	input  prg_pkg::coord_t     w_z,
	input  prg_pkg::coord_t     pw,
	input  logic                ray_valid,
	input  logic                ray_ready,
	input  prg_pkg::coord_t     ray_origin_x,
	input  prg_pkg::coord_t     ray_origin_y,
	input  prg_pkg::coord_t     ray_origin_z,
	input  prg_pkg::coord_t     ray_dir_x,
	input  prg_pkg::coord_t     ray_dir_y,
	input  prg_pkg::coord_t     ray_dir_z,
	input  prg_pkg::pixel_id_t  ray_pixel_id
);
	import prg_pkg::*;

	typedef struct packed {
		coord_t ox;
		coord_t oy;
		coord_t oz;
		coord_t dx;
		coord_t dy;
		coord_t dz;
	} ray_t;

	string     test_name = "reset";
	int        error_count = 0;
	int        rays_seen = 0;
	int        expected_pid;
	logic      held;
	pixel_id_t held_pid;
	ray_t      held_ray;
	ray_t      exp_ray;
	ray_t      act_ray;

	// Q8.8 times Q8.8 in 32 bits, back to Q8.8
	function automatic int scaled_term(input coord_t s, input coord_t c);
		int prod;
		prod = int'(s) * int'(c);
		return prod >>> FRAC_BITS;
	endfunction

	function automatic ray_t expected_ray(input int pixel,
			input coord_t ex, ey, ez, input coord_t ux, uy, uz,
			input coord_t vx, vy, vz, input coord_t wx, wy, wz, input coord_t width);
		ray_t   r;
		int     x_off;
		int     y_off;
		coord_t su;
		coord_t sv;
		x_off = (pixel % NUM_COLS) - NUM_COLS / 2;
		y_off = (NUM_ROWS - 1 - pixel / NUM_COLS) - NUM_ROWS / 2;
		su = coord_t'(x_off * width);
		sv = coord_t'(y_off * width);
		r.ox = ex;
		r.oy = ey;
		r.oz = ez;
		r.dx = coord_t'(int'(wx) + scaled_term(su, ux) + scaled_term(sv, vx));
		r.dy = coord_t'(int'(wy) + scaled_term(su, uy) + scaled_term(sv, vy));
		r.dz = coord_t'(int'(wz) + scaled_term(su, uz) + scaled_term(sv, vz));
		return r;
	endfunction

	task automatic compare_value(input string check, input string field,
			input int expected, input int actual);
		if (expected != actual) begin
			error_count++;
			$display("MISMATCH %s (%s %s): expected %0d, actual %0d",
				test_name, check, field, expected, actual);
		end
	endtask

	task automatic compare_ray(input string check, input ray_t expected, input ray_t actual);
		compare_value(check, "origin_x", expected.ox, actual.ox);
		compare_value(check, "origin_y", expected.oy, actual.oy);
		compare_value(check, "origin_z", expected.oz, actual.oz);
		compare_value(check, "dir_x", expected.dx, actual.dx);
		compare_value(check, "dir_y", expected.dy, actual.dy);
		compare_value(check, "dir_z", expected.dz, actual.dz);
	endtask

	// ########################################################################
	// Transfer and stall checks
	// ########################################################################

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			expected_pid = 0;
			held = 1'b0;
		end else begin
			act_ray = {ray_origin_x, ray_origin_y, ray_origin_z, ray_dir_x, ray_dir_y, ray_dir_z};
			// A ray offered to a stalled shader has to stay put
			if (held) begin
				compare_value("stall", "ray_valid", 1, ray_valid);
				compare_value("stall", "pixel_id", held_pid, ray_pixel_id);
				compare_ray("stall", held_ray, act_ray);
			end
			if (ray_valid && ray_ready) begin
				exp_ray = expected_ray(expected_pid, eye_x, eye_y, eye_z, u_x, u_y, u_z,
					v_x, v_y, v_z, w_x, w_y, w_z, pw);
				compare_value("order", "pixel_id", expected_pid, ray_pixel_id);
				compare_ray("value", exp_ray, act_ray);
				rays_seen++;
				expected_pid = (expected_pid == NUM_RAYS - 1) ? 0 : expected_pid + 1;
			end
			held = ray_valid && !ray_ready;
			held_pid = ray_pixel_id;
			held_ray = act_ray;
		end
	end

endmodule : prg_checker

// ==== testbench/prg_tb.sv ====
`timescale 1ns/1ps

module prg_tb;
	import prg_pkg::*;

	localparam int NUM_FRAMES = 3;
	localparam int WAIT_LIMIT = 5000;
	localparam int SEED_INIT  = 89;

	// Camera words in port order: eye, u, v and w as x y z, then pw
	localparam logic [0:12][15:0] CAMERA_A = {16'h0180, 16'hFE00, 16'h0A40,
		16'h0100, 16'h0040, 16'hFF80, 16'hFFE0, 16'h00C0, 16'h0080,
		16'h0080, 16'hFFA0, 16'hFC00, 16'h0060};
	localparam logic [0:12][15:0] CAMERA_B = {16'hFD00, 16'h0080, 16'hFEC0,
		16'h00E0, 16'hFF80, 16'h0020, 16'h0040, 16'h0140, 16'hFF60,
		16'hFE80, 16'h0200, 16'h03C0, 16'h0180};

	logic              clk;
	logic              rst;
	logic              start;
	logic              ray_ready;
	logic [0:12][15:0] camera;
	logic              ray_valid;
	coord_t            ray_origin_x, ray_origin_y, ray_origin_z;
	coord_t            ray_dir_x, ray_dir_y, ray_dir_z;
	pixel_id_t         ray_pixel_id;
	logic              busy;

	integer seed = SEED_INIT;
	integer rnd;
	int     ready_mode = 0;
	int     prev_mode = 0;
	int     low_hold = 0;
	int     tb_errors = 0;
	logic   timed_out = 1'b0;

	prg i_dut (
		.clk, .rst, .start,
		.eye_x(camera[0]), .eye_y(camera[1]), .eye_z(camera[2]),
		.u_x(camera[3]), .u_y(camera[4]), .u_z(camera[5]),
		.v_x(camera[6]), .v_y(camera[7]), .v_z(camera[8]),
		.w_x(camera[9]), .w_y(camera[10]), .w_z(camera[11]), .pw(camera[12]),
		.ray_ready, .ray_valid, .ray_origin_x, .ray_origin_y, .ray_origin_z,
		.ray_dir_x, .ray_dir_y, .ray_dir_z, .ray_pixel_id, .busy
	);

	prg_checker i_checker (
		.clk, .rst,
		.eye_x(camera[0]), .eye_y(camera[1]), .eye_z(camera[2]),
		.u_x(camera[3]), .u_y(camera[4]), .u_z(camera[5]),
		.v_x(camera[6]), .v_y(camera[7]), .v_z(camera[8]),
		.w_x(camera[9]), .w_y(camera[10]), .w_z(camera[11]), .pw(camera[12]),
		.ray_valid, .ray_ready, .ray_origin_x, .ray_origin_y, .ray_origin_z,
		.ray_dir_x, .ray_dir_y, .ray_dir_z, .ray_pixel_id
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Shader ready: off, always on, or random with long low stretches
	always @(negedge clk) begin
		if (ready_mode == 2 && prev_mode != 2)
			low_hold = 2 * FIFO_DEPTH;
		prev_mode = ready_mode;
		if (ready_mode == 0) begin
			ray_ready = 1'b0;
		end else if (ready_mode == 1) begin
			ray_ready = 1'b1;
		end else if (low_hold > 0) begin
			ray_ready = 1'b0;
			low_hold--;
		end else begin
			rnd = $random(seed);
			if (rnd[4:0] == 5'd0)
				low_hold = FIFO_DEPTH + 3 + rnd[7:5];
			ray_ready = rnd[8] | rnd[9];
		end
	end

	task automatic check_low(input string signal_name, input logic actual);
		if (actual !== 1'b0) begin
			tb_errors++;
			$display("MISMATCH %s %s: expected 0, actual %b",
				i_checker.test_name, signal_name, actual);
		end
	endtask

	task automatic wait_busy(input logic level, input string what);
		int n;
		n = 0;
		while (busy !== level && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (busy !== level) begin
			tb_errors++;
			timed_out = 1'b1;
			$display("Timeout: busy never went to %b while %s", level, what);
		end
	endtask

	task automatic wait_rays(input int target, input string what);
		int n;
		n = 0;
		while (i_checker.rays_seen < target && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (i_checker.rays_seen < target) begin
			tb_errors++;
			timed_out = 1'b1;
			$display("Timeout: only %0d of %0d rays arrived while waiting for %s",
				i_checker.rays_seen, target, what);
		end
	endtask

	task automatic pulse_start();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// ########################################################################
	// One frame, with a stray start pulse once it is running
	// ########################################################################

	task automatic run_frame(input int frame);
		int base;
		int saved_mode;
		base = frame * NUM_RAYS;
		@(negedge clk);
		case (frame)
			0: i_checker.test_name = "frame_ready";
			1: i_checker.test_name = "frame_backpressure";
			default: i_checker.test_name = "frame_new_camera";
		endcase
		camera = (frame < 2) ? CAMERA_A : CAMERA_B;
		ready_mode = (frame == 0) ? 1 : 2;
		pulse_start();
		wait_busy(1'b1, "starting the frame");
		if (timed_out)
			return;
		wait_rays(base + 4, "the first rays");
		if (timed_out)
			return;
		pulse_start();
		wait_rays(base + NUM_RAYS - FIFO_DEPTH, "most of the frame");
		if (timed_out)
			return;
		// With the shader held off the scanner issues its last pixels and goes idle
		// while the full FIFO still keeps rays outstanding
		saved_mode = ready_mode;
		ready_mode = 0;
		repeat (FIFO_DEPTH + PIPE_LATENCY + 2) @(negedge clk);
		if (busy !== 1'b1) begin
			tb_errors++;
			$display("MISMATCH %s busy with rays outstanding: expected 1, actual %b",
				i_checker.test_name, busy);
		end
		pulse_start();
		ready_mode = saved_mode;
		wait_rays(base + NUM_RAYS, "the rest of the frame");
		if (timed_out)
			return;
		wait_busy(1'b0, "finishing the frame");
		if (timed_out)
			return;
		repeat (5) @(negedge clk);
		check_low("ray_valid after frame", ray_valid);
		if (i_checker.rays_seen != base + NUM_RAYS) begin
			tb_errors++;
			$display("MISMATCH %s ray_count: expected %0d, actual %0d",
				i_checker.test_name, base + NUM_RAYS, i_checker.rays_seen);
		end
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		ray_ready = 1'b0;
		camera = CAMERA_A;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_low("ray_valid", ray_valid);
		check_low("busy", busy);
		ready_mode = 1;
		repeat (12) begin
			@(negedge clk);
			check_low("ray_valid before start", ray_valid);
			check_low("busy before start", busy);
		end
		for (int f = 0; f < NUM_FRAMES && !timed_out; f++)
			run_frame(f);
		$display("Error count: %0d checker, %0d testbench",
			i_checker.error_count, tb_errors);
		if (!timed_out && i_checker.error_count == 0 && tb_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule : prg_tb
